// File: verilog/lrelu_pkg.sv
package lrelu_pkg;

  localparam int WORD_W  = 16;
  localparam int KW_BITS = 4;
  localparam int KH_BITS = 4;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [KW_BITS-1:0] kw_t;
  typedef logic [KH_BITS-1:0] kh_t;

  typedef enum logic [1:0] {
    S_IDLE   = 2'd0,
    S_REG_D  = 2'd1,
    S_BRAM_A = 2'd2,
    S_BRAM_B = 2'd3
  } w_sel_t;

  function automatic int ceil_div(input int num, input int den);
    return (num + den - 1) / den;
  endfunction

  // Beats for one row group of BRAM B in column ring clr_i.
  function automatic int calc_beats_b(input int clr_i, input int kw2, input int members);
    int clr_kw;
    int kw;
    int width_bi;
    int write_depth;
    clr_kw      = 2 * clr_i + 1;
    kw          = 2 * kw2 + 1;
    width_bi    = members / clr_kw;
    write_depth = 2 * (members / kw);
    return ceil_div(write_depth, width_bi);
  endfunction

  function automatic int calc_beats_max(input int kernel_w_max, input int members);
    int beats_max;
    beats_max = 2;                                          // Largest BRAM A run.
    for (int kw2 = 0; kw2 <= kernel_w_max / 2; kw2++) begin
      for (int clr = 0; clr <= kw2; clr++) begin
        if (calc_beats_b(clr, kw2, members) > beats_max) begin
          beats_max = calc_beats_b(clr, kw2, members);
        end
      end
    end
    return beats_max;
  endfunction

  function automatic int calc_beats_total(input int kw2, input int members);
    int total;
    total = 1 + ceil_div(2, 2 * kw2 + 1);                   // D register and BRAM A.
    for (int clr = 0; clr <= kw2; clr++) begin
      total += (2 * clr + 1) * calc_beats_b(clr, kw2, members);
    end
    return total;
  endfunction

  function automatic int clr_bits(input int kernel_w_max);
    return (kernel_w_max / 2 > 0) ? $clog2(kernel_w_max / 2 + 1) : 1;
  endfunction

  function automatic int addr_bits(input int kernel_w_max, input int members);
    return $clog2(calc_beats_max(kernel_w_max, members));
  endfunction

endpackage

// File: verilog/lrelu_kernel_cfg.sv
`timescale 1ns/1ps

module lrelu_kernel_cfg import lrelu_pkg::*; (
  input  logic clk,
  input  logic rst_n_i,
  input  logic cfg_we_i,
  input  kw_t  kw_1_i,
  input  kh_t  kh_1_i,
  output kw_t  kw_1_o,
  output kh_t  kh_1_o,
  output logic restart_o
);

  kw_t  kw_1_q;
  kh_t  kh_1_q;
  logic restart_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      kw_1_q    <= '0;
      kh_1_q    <= '0;
      restart_q <= 1'b0;
    end else begin
      if (cfg_we_i) begin
        kw_1_q <= kw_1_i;
        kh_1_q <= kh_1_i;
      end
      restart_q <= cfg_we_i;  // New fields are visible when the pulse arrives.
    end
  end

  assign kw_1_o    = kw_1_q;
  assign kh_1_o    = kh_1_q;
  assign restart_o = restart_q;

endmodule

// File: verilog/lrelu_beats_counter.sv
`timescale 1ns/1ps

module lrelu_beats_counter import lrelu_pkg::*; #(
  parameter  int MEMBERS      = 8,
  parameter  int KERNEL_W_MAX = 7,
  localparam int CLR_MAX      = KERNEL_W_MAX / 2,
  localparam int CLR_W        = clr_bits(KERNEL_W_MAX),
  localparam int ADDR_W       = addr_bits(KERNEL_W_MAX, MEMBERS)
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              restart_i,
  input  logic              en_i,
  input  kw_t               kw_1_i,
  input  kh_t               kh_1_i,
  output w_sel_t            w_sel_o,
  output logic [CLR_W-1:0]  clr_i_o,
  output kh_t               mtb_o,
  output logic [ADDR_W-1:0] w_addr_o,
  output logic              full_o
);

  w_sel_t            w_sel_q;
  w_sel_t            w_sel_next;
  logic [CLR_W-1:0]  clr_q;
  logic [CLR_W-1:0]  clr_next;
  kh_t               mtb_q;
  kh_t               mtb_next;
  logic [ADDR_W-1:0] w_addr_q;
  logic [ADDR_W-1:0] w_addr_next;
  logic [CLR_W-1:0]  kw_half;

  logic clr_last;
  logic mtb_last;
  logic a_last;
  logic b_last;
  logic en_w_addr;
  logic en_mtb;
  logic en_clr;
  logic en_w_sel;

  // Last address per kernel width for BRAM A, and per width and ring for BRAM B.
  logic [ADDR_W-1:0] lut_a [0:CLR_MAX];
  logic [ADDR_W-1:0] lut_b [0:CLR_MAX][0:CLR_MAX];

  for (genvar k = 0; k <= CLR_MAX; k++) begin : g_kw
    assign lut_a[k] = ADDR_W'(ceil_div(2, 2 * k + 1) - 1);
    for (genvar c = 0; c <= CLR_MAX; c++) begin : g_clr
      if (c <= k) begin : g_used
        assign lut_b[k][c] = ADDR_W'(calc_beats_b(c, k, MEMBERS) - 1);
      end else begin : g_unused
        assign lut_b[k][c] = '0;
      end
    end
  end

  // Widths beyond the build limit fall back to the widest table row.
  assign kw_half = (kw_1_i[KW_BITS-1:1] > CLR_MAX) ? CLR_W'(CLR_MAX)
                                                    : CLR_W'(kw_1_i[KW_BITS-1:1]);

  // Height is held for a later mtb limit; rows still stop at 2*clr_i.
  assign clr_last = (clr_q == kw_half);
  assign mtb_last = (mtb_q == kh_t'({clr_q, 1'b0}));
  assign a_last   = (w_sel_q == S_BRAM_A) && (w_addr_q == lut_a[kw_half]);
  assign b_last   = (w_sel_q == S_BRAM_B) && (w_addr_q == lut_b[kw_half][clr_q]);

  assign full_o = b_last && mtb_last && clr_last;

  assign en_w_addr = en_i && (w_sel_q != S_REG_D);
  assign en_mtb    = en_w_addr && b_last;
  assign en_clr    = en_mtb && mtb_last;

  assign clr_next    = clr_last ? '0 : clr_q + 1'b1;
  assign mtb_next    = mtb_last ? '0 : mtb_q + 1'b1;
  assign w_addr_next = (a_last || b_last) ? '0 : w_addr_q + 1'b1;

  always_comb begin
    case (w_sel_q)
      S_REG_D:  w_sel_next = S_BRAM_A;
      S_BRAM_A: w_sel_next = S_BRAM_B;
      default:  w_sel_next = S_REG_D;
    endcase
  end

  always_comb begin
    case (w_sel_q)
      S_REG_D:  en_w_sel = en_i;                  // One beat only.
      S_BRAM_A: en_w_sel = en_w_addr && a_last;
      S_BRAM_B: en_w_sel = en_clr && clr_last;  // Whole sequence done.
      default:  en_w_sel = en_i;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_sel_q  <= S_REG_D;
      clr_q    <= '0;
      mtb_q    <= '0;
      w_addr_q <= '0;
    end else if (restart_i) begin
      w_sel_q  <= S_REG_D;
      clr_q    <= '0;
      mtb_q    <= '0;
      w_addr_q <= '0;
    end else begin
      if (en_w_sel) w_sel_q <= w_sel_next;
      if (en_clr) clr_q <= clr_next;
      if (en_mtb) mtb_q <= mtb_next;
      if (en_w_addr) w_addr_q <= w_addr_next;
    end
  end

  assign w_sel_o  = w_sel_q;
  assign clr_i_o  = clr_q;
  assign mtb_o    = mtb_q;
  assign w_addr_o = w_addr_q;

endmodule

// File: verilog/lrelu_weight_store.sv
`timescale 1ns/1ps

module lrelu_weight_store import lrelu_pkg::*; #(
  parameter  int MEMBERS      = 8,
  parameter  int KERNEL_W_MAX = 7,
  localparam int CLR_W        = clr_bits(KERNEL_W_MAX),
  localparam int ADDR_W       = addr_bits(KERNEL_W_MAX, MEMBERS),
  localparam int B_AW         = CLR_W + KH_BITS + ADDR_W
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              wr_en_i,
  input  word_t             wr_data_i,
  input  w_sel_t            w_sel_i,
  input  logic [CLR_W-1:0]  clr_i_i,
  input  kh_t               mtb_i,
  input  logic [ADDR_W-1:0] w_addr_i,
  input  w_sel_t            rd_sel_i,
  input  logic [CLR_W-1:0]  rd_clr_i,
  input  kh_t               rd_mtb_i,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output word_t             rd_data_o
);

  word_t d_reg;
  word_t bram_a [0:(1 << ADDR_W)-1];
  word_t bram_b [0:(1 << B_AW)-1];

  logic [B_AW-1:0] wr_addr_b;
  logic [B_AW-1:0] rd_addr_b;
  logic            we_d;
  logic            we_a;
  logic            we_b;

  // BRAM B is laid out ring by ring, then row group, then beat.
  assign wr_addr_b = {clr_i_i, mtb_i, w_addr_i};
  assign rd_addr_b = {rd_clr_i, rd_mtb_i, rd_addr_i};

  assign we_d = wr_en_i && (w_sel_i == S_REG_D);
  assign we_a = wr_en_i && (w_sel_i == S_BRAM_A);
  assign we_b = wr_en_i && (w_sel_i == S_BRAM_B);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      d_reg <= '0;
    end else if (we_d) begin
      d_reg <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (we_a) begin
      bram_a[w_addr_i] <= wr_data_i;
    end
    if (we_b) begin
      bram_b[wr_addr_b] <= wr_data_i;
    end
  end

  // Registered read, one cycle after the select.
  always_ff @(posedge clk) begin
    case (rd_sel_i)
      S_REG_D:  rd_data_o <= d_reg;
      S_BRAM_A: rd_data_o <= bram_a[rd_addr_i];
      S_BRAM_B: rd_data_o <= bram_b[rd_addr_b];
      default:  rd_data_o <= '0;
    endcase
  end

endmodule

// File: verilog/lrelu_loader_top.sv
`timescale 1ns/1ps

module lrelu_loader_top import lrelu_pkg::*; #(
  parameter  int MEMBERS      = 8,
  parameter  int KERNEL_W_MAX = 7,
  localparam int CLR_W        = clr_bits(KERNEL_W_MAX),
  localparam int ADDR_W       = addr_bits(KERNEL_W_MAX, MEMBERS)
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              cfg_we_i,
  input  kw_t               kw_1_i,
  input  kh_t               kh_1_i,
  input  logic              beat_valid_i,
  input  word_t             beat_data_i,
  input  w_sel_t            rd_sel_i,
  input  logic [CLR_W-1:0]  rd_clr_i,
  input  kh_t               rd_mtb_i,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output word_t             rd_data_o,
  output logic              full_o
);

  kw_t               kw_1;
  kh_t               kh_1;
  logic              restart;
  logic              beat_en;
  w_sel_t            w_sel;
  logic [CLR_W-1:0]  clr_i;
  kh_t               mtb;
  logic [ADDR_W-1:0] w_addr;

  assign beat_en = beat_valid_i && !restart;  // A beat during restart is dropped.

  lrelu_kernel_cfg lrelu_kernel_cfg_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .cfg_we_i  (cfg_we_i),
    .kw_1_i    (kw_1_i),
    .kh_1_i    (kh_1_i),
    .kw_1_o    (kw_1),
    .kh_1_o    (kh_1),
    .restart_o (restart)
  );

  lrelu_beats_counter #(.MEMBERS(MEMBERS), .KERNEL_W_MAX(KERNEL_W_MAX)) lrelu_beats_counter_i (
    .clk (clk), .rst_n_i (rst_n_i), .restart_i (restart), .en_i (beat_en),
    .kw_1_i (kw_1), .kh_1_i (kh_1), .w_sel_o (w_sel), .clr_i_o (clr_i),
    .mtb_o (mtb), .w_addr_o (w_addr), .full_o (full_o)
  );

  lrelu_weight_store #(.MEMBERS(MEMBERS), .KERNEL_W_MAX(KERNEL_W_MAX)) lrelu_weight_store_i (
    .clk (clk), .rst_n_i (rst_n_i), .wr_en_i (beat_en), .wr_data_i (beat_data_i),
    .w_sel_i (w_sel), .clr_i_i (clr_i), .mtb_i (mtb), .w_addr_i (w_addr),
    .rd_sel_i (rd_sel_i), .rd_clr_i (rd_clr_i), .rd_mtb_i (rd_mtb_i),
    .rd_addr_i (rd_addr_i), .rd_data_o (rd_data_o)
  );

endmodule

// File: sim/lrelu_loader_chk.sv
`timescale 1ns/1ps

module lrelu_loader_chk import lrelu_pkg::*; #(
  parameter int CLR_W = 2
) (
  input logic             clk,
  input logic             rst_n_i,
  input logic             restart_i,
  input logic             en_i,
  input kw_t              kw_1_i,
  input w_sel_t           w_sel_i,
  input logic [CLR_W-1:0] clr_i_i,
  input kh_t              mtb_i,
  input logic             full_i
);

  int fail_count = 0;

  // A new width only counts once the restart has cleared the indices.
  a_clr_range: assert property (@(posedge clk) disable iff (!rst_n_i || restart_i)
    int'(clr_i_i) <= int'(kw_1_i) / 2)
    else begin
      fail_count++;
      $error("Column ring index %0d is beyond kw_1/2", clr_i_i);
    end

  a_mtb_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    int'(mtb_i) <= 2 * int'(clr_i_i))
    else begin
      fail_count++;
      $error("Row group %0d is beyond 2*clr_i", mtb_i);
    end

  // The last BRAM B beat wraps the counter back to the D register.
  a_full_wraps: assert property (@(posedge clk) disable iff (!rst_n_i)
    full_i && en_i |=> (w_sel_i == S_REG_D) && (clr_i_i == '0) && (mtb_i == '0))
    else begin
      fail_count++;
      $error("Counter did not wrap to the D register after the last beat");
    end

endmodule

bind lrelu_beats_counter lrelu_loader_chk #(.CLR_W(CLR_W)) lrelu_loader_chk_i (
  .clk (clk), .rst_n_i (rst_n_i), .restart_i (restart_i), .en_i (en_i), .kw_1_i (kw_1_i),
  .w_sel_i (w_sel_q), .clr_i_i (clr_q), .mtb_i (mtb_q), .full_i (full_o)
);

// File: sim/lrelu_loader_tb.sv
`timescale 1ns/1ps

module lrelu_loader_tb import lrelu_pkg::*; ();

  localparam int MEMBERS      = 8;
  localparam int KERNEL_W_MAX = 7;
  localparam int CLR_MAX      = KERNEL_W_MAX / 2;
  localparam int CLR_W        = clr_bits(KERNEL_W_MAX);
  localparam int ADDR_W       = addr_bits(KERNEL_W_MAX, MEMBERS);
  localparam int NUM_TESTS    = 8;

  logic              clk, rst_n_i, cfg_we_i, beat_valid_i, full_o;
  kw_t               kw_1_i;
  kh_t               kh_1_i, rd_mtb_i;
  word_t             beat_data_i, rd_data_o;
  w_sel_t            rd_sel_i;
  logic [CLR_W-1:0]  rd_clr_i;
  logic [ADDR_W-1:0] rd_addr_i;

  w_sel_t m_sel;  // Model position in the sequence.
  int     m_kw2, m_clr, m_mtb, m_addr;
  word_t  model_d;
  word_t  model_a [0:(1<<ADDR_W)-1];
  word_t  model_b [0:CLR_MAX][0:2*CLR_MAX][0:(1<<ADDR_W)-1];
  int     error_count = 0, errors_at_start = 0, test_count = 0, failed_tests = 0;
  string  test_name;
  integer seed = 89;

  lrelu_loader_top #(.MEMBERS(MEMBERS), .KERNEL_W_MAX(KERNEL_W_MAX)) lrelu_loader_top_i (
    .clk (clk), .rst_n_i (rst_n_i), .cfg_we_i (cfg_we_i), .kw_1_i (kw_1_i), .kh_1_i (kh_1_i),
    .beat_valid_i (beat_valid_i), .beat_data_i (beat_data_i), .rd_sel_i (rd_sel_i),
    .rd_clr_i (rd_clr_i), .rd_mtb_i (rd_mtb_i), .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o), .full_o (full_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Each BRAM B row group spreads 2*(MEMBERS/kw) words over MEMBERS/(2*ring+1) lanes.
  function automatic int group_beats(input int ring, input int kw2);
    int words;
    int lanes;
    words = 2 * (MEMBERS / (2 * kw2 + 1));
    lanes = MEMBERS / (2 * ring + 1);
    return (words + lanes - 1) / lanes;
  endfunction

  function automatic int a_beats(input int kw2);
    return (kw2 == 0) ? 2 : 1;  // Two words over kw lanes.
  endfunction

  function automatic int seq_length(input int kw2);
    int n;
    n = 1 + a_beats(kw2);
    for (int ring = 0; ring <= kw2; ring++)
      n += (2 * ring + 1) * group_beats(ring, kw2);
    return n;
  endfunction

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      error_count++;
      $display("ERROR %s, %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_full(input string what, input bit exp, input bit act);
    if (exp !== act) begin
      error_count++;
      $display("ERROR %s, %s: expected %0b, actual %0b", test_name, what, exp, act);
    end
  endtask

  // Stores a beat at the model position, then steps the nested counters.
  task automatic model_accept(input word_t data);
    if (m_sel == S_REG_D) begin
      model_d = data;
      m_sel   = S_BRAM_A;
    end else if (m_sel == S_BRAM_A) begin
      model_a[m_addr] = data;
      m_addr = (m_addr == a_beats(m_kw2) - 1) ? 0 : m_addr + 1;
      if (m_addr == 0) m_sel = S_BRAM_B;
    end else begin
      model_b[m_clr][m_mtb][m_addr] = data;
      m_addr = (m_addr == group_beats(m_clr, m_kw2) - 1) ? 0 : m_addr + 1;
      if (m_addr == 0) m_mtb = (m_mtb == 2 * m_clr) ? 0 : m_mtb + 1;
      if (m_addr == 0 && m_mtb == 0) m_clr = (m_clr == m_kw2) ? 0 : m_clr + 1;
      if (m_addr == 0 && m_mtb == 0 && m_clr == 0) m_sel = S_REG_D;
    end
  endtask

  // The loader restarts one cycle after the write, with the new width in place.
  task automatic write_config(input int kw);
    @(posedge clk);
    cfg_we_i     <= 1'b1;
    kw_1_i       <= kw_t'(kw - 1);
    kh_1_i       <= kh_t'(kw - 1);
    beat_valid_i <= 1'b0;
    @(posedge clk);
    cfg_we_i <= 1'b0;
    m_kw2  = (kw - 1) / 2;
    m_sel  = S_REG_D;
    m_clr  = 0;
    m_mtb  = 0;
    m_addr = 0;
  endtask

  task automatic send_beats(input int first, input int last, input int total, input bit gaps);
    word_t data;
    int    idle;
    for (int n = first; n <= last; n++) begin
      data = word_t'($random(seed));
      @(posedge clk);
      beat_valid_i <= 1'b1;
      beat_data_i  <= data;
      @(negedge clk);
      check_full($sformatf("full_o at beat %0d", n), n == total, full_o);
      model_accept(data);
      idle = gaps ? $unsigned($random(seed)) % 4 : 0;
      repeat (idle) begin
        @(posedge clk);
        beat_valid_i <= 1'b0;
      end
    end
    @(posedge clk);
    beat_valid_i <= 1'b0;
  endtask

  task automatic read_word(input w_sel_t sel, input int ring, input int row, input int addr,
                           output word_t data);
    @(posedge clk);
    rd_sel_i  <= sel;
    rd_clr_i  <= CLR_W'(ring);
    rd_mtb_i  <= kh_t'(row);
    rd_addr_i <= ADDR_W'(addr);
    @(posedge clk);
    @(negedge clk);  // Word is registered one cycle after the select.
    data = rd_data_o;
  endtask

  task automatic check_contents();
    word_t got;
    read_word(S_REG_D, 0, 0, 0, got);
    check_word("D register", model_d, got);
    for (int a = 0; a < a_beats(m_kw2); a++) begin
      read_word(S_BRAM_A, 0, 0, a, got);
      check_word($sformatf("BRAM A[%0d]", a), model_a[a], got);
    end
    for (int c = 0; c <= m_kw2; c++) begin
      for (int r = 0; r <= 2 * c; r++) begin
        for (int a = 0; a < group_beats(c, m_kw2); a++) begin
          read_word(S_BRAM_B, c, r, a, got);
          check_word($sformatf("BRAM B[%0d][%0d][%0d]", c, r, a), model_b[c][r][a], got);
        end
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic finish_test();
    test_count++;
    if (error_count == errors_at_start) begin
      $display("Test %s passed", test_name);
    end else begin
      failed_tests++;
      $display("Test %s failed with %0d mismatches", test_name, error_count - errors_at_start);
    end
  endtask

  task automatic sequence_test(input string name, input int kw, input bit gaps);
    int total;
    total = seq_length((kw - 1) / 2);
    start_test(name);
    write_config(kw);
    send_beats(1, total, total, gaps);
    @(negedge clk);
    check_full("full_o after the sequence", 1'b0, full_o);
    check_contents();
    finish_test();
  endtask

  initial begin
    word_t got;
    int    assert_fails;
    rst_n_i      = 1'b0;
    cfg_we_i     = 1'b0;
    kw_1_i       = '0;
    kh_1_i       = '0;
    beat_valid_i = 1'b0;
    beat_data_i  = '0;
    rd_sel_i     = S_IDLE;
    rd_clr_i     = '0;
    rd_mtb_i     = '0;
    rd_addr_i    = '0;
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;
    start_test("reset");
    @(negedge clk);
    check_full("full_o after reset", 1'b0, full_o);
    read_word(S_REG_D, 0, 0, 0, got);
    check_word("D register after reset", '0, got);
    finish_test();
    sequence_test("kw1", 1, 1'b0);
    sequence_test("kw3", 3, 1'b0);
    sequence_test("kw5", 5, 1'b0);
    sequence_test("kw7", 7, 1'b0);
    sequence_test("gaps_kw5", 5, 1'b1);
    sequence_test("gaps_kw7", 7, 1'b1);
    // A width change part way through a kw 3 sequence.
    start_test("restart");
    write_config(3);
    send_beats(1, 4, seq_length(1), 1'b0);
    write_config(7);
    send_beats(1, 1, seq_length(3), 1'b0);
    read_word(S_REG_D, 0, 0, 0, got);
    check_word("D register after restart", model_d, got);
    send_beats(2, seq_length(3), seq_length(3), 1'b0);
    check_contents();
    finish_test();
    assert_fails = lrelu_loader_top_i.lrelu_beats_counter_i.lrelu_loader_chk_i.fail_count;
    $display("Tests run %0d, tests failed %0d, mismatches %0d, assertion failures %0d",
             test_count, failed_tests, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    int limit;
    limit = NUM_TESTS * seq_length(CLR_MAX) * 4 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock periods", limit);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: list.f
verilog/lrelu_pkg.sv
verilog/lrelu_kernel_cfg.sv
verilog/lrelu_beats_counter.sv
verilog/lrelu_weight_store.sv
verilog/lrelu_loader_top.sv
sim/lrelu_loader_chk.sv
sim/lrelu_loader_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the loader testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module lrelu_loader_tb -o lrelu_loader_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi
./obj_dir/lrelu_loader_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if grep -qx "NO ERRORS" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
